// File: logic/hazardUnit_config.svh
`ifndef HAZARDUNIT_CONFIG_SVH
`define HAZARDUNIT_CONFIG_SVH

////////////////////////////////////////////////////////////
// Hazard unit sizing
////////////////////////////////////////////////////////////

// Architectural register index, 32 integer registers
`define REG_IDX_W 5

// Operand source select into the EX operand muxes
// Four sources: regfile, EX/MEM, MEM/WB, virtual WB
`define FWD_SEL_W 2

// Next-PC mux select toward the fetch stage
// Four sources: PC+4, BTB target, resolved target, fall-through
`define NPC_SEL_W 2

`endif

// File: logic/hazardPkg.sv
`include "hazardUnit_config.svh"

package hazardPkg;

    ////////////////////////////////////////////////////////////
    // Operand forwarding sources
    ////////////////////////////////////////////////////////////
    typedef enum logic [`FWD_SEL_W-1:0] {
        REGFILE = 2'd0,  // No hazard, read port value
        EXMEM   = 2'd1,  // ALU result sitting in EX/MEM
        MEMWB   = 2'd2,  // Value being written back
        VWB     = 2'd3   // Held one cycle past WB
    } fwdSrc_t;

    ////////////////////////////////////////////////////////////
    // Next-PC sources
    ////////////////////////////////////////////////////////////
    typedef enum logic [`NPC_SEL_W-1:0] {
        SEQ       = 2'd0,  // PC + 4
        PREDICTED = 2'd1,  // BTB target
        RESOLVED  = 2'd2,  // Computed branch/jump target
        FALLTHRU  = 2'd3   // Branch PC + 4 after bad taken guess
    } npcSel_t;

    ////////////////////////////////////////////////////////////
    // SPARC Bicc condition field
    ////////////////////////////////////////////////////////////
    // Upper half is the negation of the lower half
    typedef enum logic [3:0] {
        BN   = 4'h0,  // Never
        BE   = 4'h1,  // Z
        BLE  = 4'h2,  // Z | (N ^ V)
        BL   = 4'h3,  // N ^ V
        BLEU = 4'h4,  // C | Z
        BCS  = 4'h5,  // C
        BNEG = 4'h6,  // N
        BVS  = 4'h7,  // V
        BA   = 4'h8,  // Always
        BNE  = 4'h9,  // !Z
        BG   = 4'hA,  // Signed greater
        BGE  = 4'hB,  // Signed greater or equal
        BGU  = 4'hC,  // Unsigned greater
        BCC  = 4'hD,  // !C
        BPOS = 4'hE,  // !N
        BVC  = 4'hF   // !V
    } cond_t;

endpackage

// File: logic/forwardUnit.sv
`timescale 1ns/100ps
`include "hazardUnit_config.svh"

module forwardUnit (
    // IF/ID, store data read in ID
    input  logic                  i_ifIdNeedRs2,
    input  logic [`REG_IDX_W-1:0] i_ifIdRs2,
    // ID/EX, operands consumed in EX
    input  logic                  i_idExNeedRs1,
    input  logic                  i_idExNeedRs2,
    input  logic [`REG_IDX_W-1:0] i_idExRs1,
    input  logic [`REG_IDX_W-1:0] i_idExRs2,
    // EX/MEM producer
    input  logic                  i_exMemRegWe,
    input  logic [`REG_IDX_W-1:0] i_exMemRdst,
    input  logic                  i_exMemIsLoad,   // Data not ready until after MEM
    // MEM/WB producer
    input  logic                  i_memWbRegWe,
    input  logic [`REG_IDX_W-1:0] i_memWbRdst,
    // Virtual write-back, one cycle past WB
    input  logic                  i_vwbRegWe,
    input  logic [`REG_IDX_W-1:0] i_vwbRdst,
    // Selects
    output hazardPkg::fwdSrc_t    o_opOneExSel,
    output hazardPkg::fwdSrc_t    o_opTwoExSel,
    output logic                  o_opTwoIdSel,    // Store data from MEM/WB
    output logic                  o_needStall      // Load-use bubble request
);

    import hazardPkg::*;

    // Producer writes the register a consumer needs, r0 excluded
    function automatic logic producerHit(
        input logic                  need,
        input logic                  we,
        input logic [`REG_IDX_W-1:0] rdst,
        input logic [`REG_IDX_W-1:0] rs
    );
        return need && we && (rdst != '0) && (rdst == rs);
    endfunction

    // Youngest producer wins
    function automatic fwdSrc_t youngestSrc(
        input logic exHit,
        input logic exLoad,
        input logic memHit,
        input logic vwbHit
    );
        fwdSrc_t src;
        if (exHit && !exLoad) begin
            src = EXMEM;
        end else if (memHit) begin    // Load in EX/MEM falls through here
            src = MEMWB;
        end else if (vwbHit) begin
            src = VWB;
        end else begin
            src = REGFILE;
        end
        return src;
    endfunction

    logic exHitOne;
    logic memHitOne;
    logic vwbHitOne;
    logic exHitTwo;
    logic memHitTwo;
    logic vwbHitTwo;

    ////////////////////////////////////////////////////////////
    // Producer matches per EX operand
    ////////////////////////////////////////////////////////////
    assign exHitOne  = producerHit(i_idExNeedRs1, i_exMemRegWe, i_exMemRdst, i_idExRs1);
    assign memHitOne = producerHit(i_idExNeedRs1, i_memWbRegWe, i_memWbRdst, i_idExRs1);
    assign vwbHitOne = producerHit(i_idExNeedRs1, i_vwbRegWe, i_vwbRdst, i_idExRs1);

    assign exHitTwo  = producerHit(i_idExNeedRs2, i_exMemRegWe, i_exMemRdst, i_idExRs2);
    assign memHitTwo = producerHit(i_idExNeedRs2, i_memWbRegWe, i_memWbRdst, i_idExRs2);
    assign vwbHitTwo = producerHit(i_idExNeedRs2, i_vwbRegWe, i_vwbRdst, i_idExRs2);

    // Operand mux selects
    assign o_opOneExSel = youngestSrc(exHitOne, i_exMemIsLoad, memHitOne, vwbHitOne);
    assign o_opTwoExSel = youngestSrc(exHitTwo, i_exMemIsLoad, memHitTwo, vwbHitTwo);

    // Load in EX/MEM feeding either operand needs one bubble
    assign o_needStall = i_exMemIsLoad && (exHitOne || exHitTwo);

    // Store data bypass in ID
    assign o_opTwoIdSel = producerHit(i_ifIdNeedRs2, i_memWbRegWe, i_memWbRdst, i_ifIdRs2);

endmodule

// File: logic/conditionCheck.sv
`timescale 1ns/100ps

module conditionCheck (
    input  logic             [3:0] i_cc,            // N Z V C
    input  hazardPkg::cond_t       i_cond,          // Bicc cond field
    output logic                   o_branchTaken
);

    import hazardPkg::*;

    logic flagN;
    logic flagZ;
    logic flagV;
    logic flagC;
    logic baseTrue;    // Lower-half condition value

    // Unpack flags
    assign flagN = i_cc[3];
    assign flagZ = i_cc[2];
    assign flagV = i_cc[1];
    assign flagC = i_cc[0];

    ////////////////////////////////////////////////////////////
    // Bicc table, each pair shares one term
    ////////////////////////////////////////////////////////////
    always_comb begin
        unique case (i_cond)
            BN,   BA:   baseTrue = 1'b0;                      // Never / always
            BE,   BNE:  baseTrue = flagZ;                     // Equal
            BLE,  BG:   baseTrue = flagZ | (flagN ^ flagV);   // Signed less or equal
            BL,   BGE:  baseTrue = flagN ^ flagV;             // Signed less
            BLEU, BGU:  baseTrue = flagC | flagZ;             // Unsigned less or equal
            BCS,  BCC:  baseTrue = flagC;                     // Carry set
            BNEG, BPOS: baseTrue = flagN;                     // Negative
            BVS,  BVC:  baseTrue = flagV;                     // Overflow
        endcase
    end

    // Bit 3 inverts the sense
    assign o_branchTaken = baseTrue ^ i_cond[3];

endmodule

// File: logic/branchResolver.sv
`timescale 1ns/100ps

module branchResolver (
    input  logic                i_pcMatchValid,   // BTB hit for this PC
    input  logic                i_branchInstr,
    input  logic                i_jumpInstr,
    input  logic                i_branchTaken,    // Condition true
    input  logic                i_targetMatch,    // BTB target equals computed one
    input  logic          [1:0] i_ctrlIn,         // 2-bit counter from BTB
    output logic          [1:0] o_ctrlOut,        // Counter to write back
    output hazardPkg::npcSel_t  o_npcSel,
    output logic                o_redirect,       // Wrong path fetched
    output logic                o_btbUpdate       // Control transfer seen
);

    import hazardPkg::*;

    logic predTaken;
    logic actualTaken;
    logic dirMiss;       // Direction disagrees
    logic targetMiss;    // Both taken, targets differ

    ////////////////////////////////////////////////////////////
    // Prediction vs outcome
    ////////////////////////////////////////////////////////////
    assign predTaken   = i_pcMatchValid & i_ctrlIn[1];           // Weakly/strongly taken
    assign actualTaken = i_jumpInstr | (i_branchInstr & i_branchTaken);

    assign dirMiss    = predTaken ^ actualTaken;
    assign targetMiss = predTaken & actualTaken & ~i_targetMatch;
    assign o_redirect = dirMiss | targetMiss;

    // Next PC choice
    always_comb begin
        if (o_redirect && actualTaken) begin
            o_npcSel = RESOLVED;    // Go to computed target
        end else if (o_redirect) begin
            o_npcSel = FALLTHRU;    // Undo a taken guess
        end else if (predTaken) begin
            o_npcSel = PREDICTED;   // Guess was right
        end else begin
            o_npcSel = SEQ;
        end
    end

    // Any branch or jump trains the BTB
    assign o_btbUpdate = i_branchInstr | i_jumpInstr;

    ////////////////////////////////////////////////////////////
    // Saturating counter
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (actualTaken) begin
            o_ctrlOut = (i_ctrlIn == 2'b11) ? 2'b11 : i_ctrlIn + 2'd1;   // Toward strong taken
        end else begin
            o_ctrlOut = (i_ctrlIn == 2'b00) ? 2'b00 : i_ctrlIn - 2'd1;   // Toward strong not
        end
    end

endmodule

// File: logic/stallUnit.sv
`timescale 1ns/100ps

module stallUnit (
    input  logic i_needStall,     // Load-use from forwarding
    input  logic i_dcacheMiss,    // MEM stage
    input  logic i_icacheMiss,    // IF stage
    input  logic i_redirect,      // Mispredict resolved in EX
    input  logic i_btbUpdate,     // Branch or jump in EX
    // Stalls
    output logic o_pcStall,
    output logic o_ifIdStall,
    output logic o_idExStall,
    output logic o_exMemStall,
    // Flushes
    output logic o_ifIdFlush,
    output logic o_idExFlush,
    output logic o_exMemFlush,
    output logic o_memWbFlush,
    // BTB
    output logic o_btbWrite
);

    ////////////////////////////////////////////////////////////
    // Priority chain
    ////////////////////////////////////////////////////////////
    always_comb begin
        o_pcStall    = 1'b0;
        o_ifIdStall  = 1'b0;
        o_idExStall  = 1'b0;
        o_exMemStall = 1'b0;
        o_ifIdFlush  = 1'b0;
        o_idExFlush  = 1'b0;
        o_memWbFlush = 1'b0;

        if (i_dcacheMiss) begin
            // Freeze front four stages and bubble into WB
            o_pcStall    = 1'b1;
            o_ifIdStall  = 1'b1;
            o_idExStall  = 1'b1;
            o_exMemStall = 1'b1;
            o_memWbFlush = 1'b1;
        end else if (i_redirect) begin
            // Kill wrong-path IF and ID with the load-use consumer
            o_ifIdFlush = 1'b1;
            o_idExFlush = 1'b1;
        end else if (i_needStall) begin
            o_pcStall   = 1'b1;   // Refetch same PC
            o_ifIdStall = 1'b1;   // Hold consumer in ID
            o_idExFlush = 1'b1;   // Bubble into EX
        end else if (i_icacheMiss) begin
            o_pcStall   = 1'b1;
            o_ifIdFlush = 1'b1;   // No valid instruction yet
        end

        // EX frozen on a data miss so the branch retrains later
        o_btbWrite = i_btbUpdate & ~i_dcacheMiss;
    end

    // Load-use never duplicates an EX result here
    assign o_exMemFlush = 1'b0;

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/100ps
`include "hazardUnit_config.svh"

module hazardUnit (
    ////////////////////////////////////////////////////////////
    // Forwarding inputs
    ////////////////////////////////////////////////////////////
    input  logic                  i_ifIdNeedRs2,
    input  logic [`REG_IDX_W-1:0] i_ifIdRs2,
    input  logic                  i_idExNeedRs1,
    input  logic                  i_idExNeedRs2,
    input  logic [`REG_IDX_W-1:0] i_idExRs1,
    input  logic [`REG_IDX_W-1:0] i_idExRs2,
    input  logic                  i_exMemRegWe,
    input  logic [`REG_IDX_W-1:0] i_exMemRdst,
    input  logic                  i_exMemIsLoad,
    input  logic                  i_memWbRegWe,
    input  logic [`REG_IDX_W-1:0] i_memWbRdst,
    input  logic                  i_vwbRegWe,
    input  logic [`REG_IDX_W-1:0] i_vwbRdst,
    // Branch inputs
    input  logic            [3:0] i_cc,            // NZVC
    input  hazardPkg::cond_t      i_cond,
    input  logic                  i_pcMatchValid,
    input  logic                  i_branchInstr,
    input  logic                  i_jumpInstr,
    input  logic                  i_targetMatch,
    input  logic            [1:0] i_ctrlIn,
    // Cache misses
    input  logic                  i_dcacheMiss,
    input  logic                  i_icacheMiss,
    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////
    output hazardPkg::fwdSrc_t    o_opOneExSel,
    output hazardPkg::fwdSrc_t    o_opTwoExSel,
    output logic                  o_opTwoIdSel,
    output logic            [1:0] o_ctrlOut,
    output hazardPkg::npcSel_t    o_npcSel,
    output logic                  o_pcStall,
    output logic                  o_ifIdStall,
    output logic                  o_idExStall,
    output logic                  o_exMemStall,
    output logic                  o_ifIdFlush,
    output logic                  o_idExFlush,
    output logic                  o_exMemFlush,
    output logic                  o_memWbFlush,
    output logic                  o_btbWrite
);

    logic needStall;     // Load-use, forward to stall
    logic branchTaken;   // Condition result
    logic redirect;      // Mispredict
    logic btbUpdate;     // Control transfer in EX

    forwardUnit forwardUnit_inst (
        .i_ifIdNeedRs2 (i_ifIdNeedRs2),
        .i_ifIdRs2     (i_ifIdRs2),
        .i_idExNeedRs1 (i_idExNeedRs1),
        .i_idExNeedRs2 (i_idExNeedRs2),
        .i_idExRs1     (i_idExRs1),
        .i_idExRs2     (i_idExRs2),
        .i_exMemRegWe  (i_exMemRegWe),
        .i_exMemRdst   (i_exMemRdst),
        .i_exMemIsLoad (i_exMemIsLoad),
        .i_memWbRegWe  (i_memWbRegWe),
        .i_memWbRdst   (i_memWbRdst),
        .i_vwbRegWe    (i_vwbRegWe),
        .i_vwbRdst     (i_vwbRdst),
        .o_opOneExSel  (o_opOneExSel),
        .o_opTwoExSel  (o_opTwoExSel),
        .o_opTwoIdSel  (o_opTwoIdSel),
        .o_needStall   (needStall)
    );

    conditionCheck conditionCheck_inst (
        .i_cc          (i_cc),
        .i_cond        (i_cond),
        .o_branchTaken (branchTaken)
    );

    branchResolver branchResolver_inst (
        .i_pcMatchValid (i_pcMatchValid),
        .i_branchInstr  (i_branchInstr),
        .i_jumpInstr    (i_jumpInstr),
        .i_branchTaken  (branchTaken),
        .i_targetMatch  (i_targetMatch),
        .i_ctrlIn       (i_ctrlIn),
        .o_ctrlOut      (o_ctrlOut),
        .o_npcSel       (o_npcSel),
        .o_redirect     (redirect),
        .o_btbUpdate    (btbUpdate)
    );

    // Sole owner of stalls and flushes
    stallUnit stallUnit_inst (
        .i_needStall  (needStall),
        .i_dcacheMiss (i_dcacheMiss),
        .i_icacheMiss (i_icacheMiss),
        .i_redirect   (redirect),
        .i_btbUpdate  (btbUpdate),
        .o_pcStall    (o_pcStall),
        .o_ifIdStall  (o_ifIdStall),
        .o_idExStall  (o_idExStall),
        .o_exMemStall (o_exMemStall),
        .o_ifIdFlush  (o_ifIdFlush),
        .o_idExFlush  (o_idExFlush),
        .o_exMemFlush (o_exMemFlush),
        .o_memWbFlush (o_memWbFlush),
        .o_btbWrite   (o_btbWrite)
    );

endmodule

// File: verif/hazardUnitTb.sv
`timescale 1ns/100ps
`include "hazardUnit_config.svh"

module hazardUnitTb;

    import hazardPkg::*;

    localparam int resetCycles   = 16;
    localparam int vecsPerTest   = 500;
    localparam int timeoutCycles = resetCycles + 6 * vecsPerTest + 100;
    localparam logic [`REG_IDX_W-1:0] regMask = 3;   // Indices r0 to r3 so collisions are common

    // Every DUT output in one word
    typedef struct packed {
        fwdSrc_t    opOne;
        fwdSrc_t    opTwo;
        logic       opTwoId;
        logic [1:0] ctrl;
        npcSel_t    npc;
        logic       pcStall, ifIdStall, idExStall, exMemStall;
        logic       ifIdFlush, idExFlush, exMemFlush, memWbFlush;
        logic       btbWrite;
    } expect_t;

    logic        clk;
    logic        i_reset;      // Paces stimulus only
    integer      seed;
    logic [31:0] rnd;
    logic        checkEn;      // Compare process active
    expect_t     expected;
    int          errorCount, vecCount, cycleCount;

    // DUT inputs named as the ports
    logic                  i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2;
    logic                  i_exMemRegWe, i_exMemIsLoad, i_memWbRegWe, i_vwbRegWe;
    logic [`REG_IDX_W-1:0] i_ifIdRs2, i_idExRs1, i_idExRs2;
    logic [`REG_IDX_W-1:0] i_exMemRdst, i_memWbRdst, i_vwbRdst;
    logic            [3:0] i_cc;   // NZVC
    cond_t                 i_cond;
    logic                  i_pcMatchValid, i_branchInstr, i_jumpInstr, i_targetMatch;
    logic            [1:0] i_ctrlIn;
    logic                  i_dcacheMiss, i_icacheMiss;

    // DUT outputs
    fwdSrc_t               o_opOneExSel, o_opTwoExSel;
    npcSel_t               o_npcSel;
    logic            [1:0] o_ctrlOut;
    logic                  o_opTwoIdSel, o_pcStall, o_ifIdStall, o_idExStall, o_exMemStall;
    logic                  o_ifIdFlush, o_idExFlush, o_exMemFlush, o_memWbFlush, o_btbWrite;

    hazardUnit hazardUnit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Oldest producer first so younger ones overwrite
    function automatic fwdSrc_t forwardSource(input logic need, input logic [`REG_IDX_W-1:0] rs);
        fwdSrc_t src;
        src = REGFILE;
        if (need && rs != '0) begin
            if (i_vwbRegWe && i_vwbRdst == rs) src = VWB;
            if (i_memWbRegWe && i_memWbRdst == rs) src = MEMWB;
            if (i_exMemRegWe && i_exMemRdst == rs && !i_exMemIsLoad) src = EXMEM;  // Load not ready
        end
        return src;
    endfunction

    // Bicc table where the upper eight codes negate the lower eight
    function automatic logic condHolds(input logic [3:0] nzvc, input cond_t c);
        logic [7:0] lower;
        logic       n, z, v, cy;
        {n, z, v, cy} = nzvc;
        lower = {v, n, cy, cy | z, n ^ v, z | (n ^ v), z, 1'b0};   // BVS down to BN
        return lower[c[2:0]] ^ c[3];
    endfunction

    function automatic expect_t refHazard();
        expect_t e;
        logic    loadUse;
        logic    predTaken;
        logic    actTaken;
        logic    redirect;
        e = '0;
        e.opOne   = forwardSource(i_idExNeedRs1, i_idExRs1);
        e.opTwo   = forwardSource(i_idExNeedRs2, i_idExRs2);
        e.opTwoId = i_ifIdNeedRs2 && i_memWbRegWe && (i_ifIdRs2 != '0)
                    && (i_memWbRdst == i_ifIdRs2);   // Store data in ID
        loadUse   = i_exMemIsLoad && i_exMemRegWe && (i_exMemRdst != '0)
                    && ((i_idExNeedRs1 && i_idExRs1 == i_exMemRdst)
                        || (i_idExNeedRs2 && i_idExRs2 == i_exMemRdst));
        predTaken = i_pcMatchValid && i_ctrlIn[1];
        actTaken  = i_jumpInstr || (i_branchInstr && condHolds(i_cc, i_cond));
        redirect  = (predTaken != actTaken) || (predTaken && actTaken && !i_targetMatch);
        if (redirect) begin
            if (actTaken) begin
                e.npc = RESOLVED;
            end else begin
                e.npc = FALLTHRU;
            end
        end else if (predTaken) begin
            e.npc = PREDICTED;
        end
        // Counter saturates at both ends
        e.ctrl = i_ctrlIn;
        if (actTaken && i_ctrlIn != 2'b11) e.ctrl = i_ctrlIn + 2'd1;
        if (!actTaken && i_ctrlIn != 2'b00) e.ctrl = i_ctrlIn - 2'd1;
        if (i_dcacheMiss) begin
            {e.pcStall, e.ifIdStall, e.idExStall, e.exMemStall, e.memWbFlush} = 5'b11111;
        end else if (redirect) begin
            {e.ifIdFlush, e.idExFlush} = 2'b11;             // Load-use dropped too
        end else if (loadUse) begin
            {e.pcStall, e.ifIdStall, e.idExFlush} = 3'b111; // Bubble
        end else if (i_icacheMiss) begin
            {e.pcStall, e.ifIdFlush} = 2'b11;
        end
        e.btbWrite = (i_branchInstr || i_jumpInstr) && !i_dcacheMiss;
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic clearInputs();
        {i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2, i_exMemRegWe, i_exMemIsLoad,
         i_memWbRegWe, i_vwbRegWe, i_pcMatchValid, i_branchInstr, i_jumpInstr,
         i_targetMatch, i_dcacheMiss, i_icacheMiss} = '0;
        {i_ifIdRs2, i_idExRs1, i_idExRs2, i_exMemRdst, i_memWbRdst, i_vwbRdst} = '0;
        i_cc     = '0;
        i_ctrlIn = '0;
        i_cond   = BN;
    endtask

    task automatic randomForward(input logic withLoad);
        rnd = $random(seed);
        i_idExRs1   = rnd[4:0] & regMask;
        i_idExRs2   = rnd[9:5] & regMask;
        i_ifIdRs2   = rnd[14:10] & regMask;
        i_exMemRdst = rnd[19:15] & regMask;
        i_memWbRdst = rnd[24:20] & regMask;
        i_vwbRdst   = rnd[29:25] & regMask;
        rnd = $random(seed);
        {i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2} = rnd[2:0];
        {i_exMemRegWe, i_memWbRegWe, i_vwbRegWe}       = rnd[5:3];
        i_exMemIsLoad = withLoad & rnd[6];
    endtask

    task automatic randomBranch();
        rnd = $random(seed);
        i_pcMatchValid = rnd[0];
        i_branchInstr  = rnd[1];
        i_jumpInstr    = ~rnd[1] & rnd[2];   // Never both
        i_targetMatch  = rnd[3];
        i_ctrlIn       = rnd[5:4];
        i_cc           = rnd[9:6];
        i_cond         = cond_t'(rnd[13:10]);
    endtask

    task automatic runTest(input int testId, input string testName);
        int startErrors;
        startErrors = errorCount;
        for (int n = 0; n < vecsPerTest; n++) begin
            @(posedge clk);
            #1;
            clearInputs();
            case (testId)
                1: randomForward(1'b0);
                2: begin
                    randomForward(1'b0);
                    i_exMemIsLoad = 1'b1;
                    i_exMemRegWe  = 1'b1;
                    i_exMemRdst   = {i_exMemRdst[`REG_IDX_W-1:1], 1'b1};   // Odd so never r0
                    if (rnd[20]) i_idExRs1 = i_exMemRdst;
                    if (rnd[21]) i_idExRs2 = i_exMemRdst;
                end
                3: begin
                    i_branchInstr = 1'b1;   // BTB miss so taken gives RESOLVED
                    i_cc          = n[7:4];
                    i_cond        = cond_t'(n[3:0]);
                end
                4: begin
                    randomBranch();
                    i_ctrlIn = n[1:0];      // Walk every counter state
                end
                5: begin
                    randomForward(1'b1);
                    randomBranch();
                    rnd = $random(seed);
                    {i_dcacheMiss, i_icacheMiss} = rnd[1:0];
                end
                6: begin
                    randomForward(1'b0);   // Indices only
                    {i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2,
                     i_exMemRegWe, i_memWbRegWe, i_vwbRegWe} = '0;
                end
                default: ;
            endcase
            checkEn = 1'b1;
            vecCount++;
        end
        @(posedge clk);
        checkEn = 1'b0;
        $display("Test %0d %s: %0d vectors, %0d errors", testId, testName, vecsPerTest,
                 errorCount - startErrors);
    endtask

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic checkField(input string name, input logic [1:0] expVal,
                              input logic [1:0] actVal);
        assert (actVal === expVal) else begin
            $display("mismatch %s: expected %h, actual %h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    // Sample late in the cycle when inputs have settled
    initial begin
        forever begin
            @(posedge clk);
            #7;
            if (checkEn) begin
                expected = refHazard();
                checkField("o_opOneExSel", expected.opOne, o_opOneExSel);
                checkField("o_opTwoExSel", expected.opTwo, o_opTwoExSel);
                checkField("o_opTwoIdSel", {1'b0, expected.opTwoId}, {1'b0, o_opTwoIdSel});
                checkField("o_ctrlOut", expected.ctrl, o_ctrlOut);
                checkField("o_npcSel", expected.npc, o_npcSel);
                checkField("o_pcStall", {1'b0, expected.pcStall}, {1'b0, o_pcStall});
                checkField("o_ifIdStall", {1'b0, expected.ifIdStall}, {1'b0, o_ifIdStall});
                checkField("o_idExStall", {1'b0, expected.idExStall}, {1'b0, o_idExStall});
                checkField("o_exMemStall", {1'b0, expected.exMemStall}, {1'b0, o_exMemStall});
                checkField("o_ifIdFlush", {1'b0, expected.ifIdFlush}, {1'b0, o_ifIdFlush});
                checkField("o_idExFlush", {1'b0, expected.idExFlush}, {1'b0, o_idExFlush});
                checkField("o_exMemFlush", {1'b0, expected.exMemFlush}, {1'b0, o_exMemFlush});
                checkField("o_memWbFlush", {1'b0, expected.memWbFlush}, {1'b0, o_memWbFlush});
                checkField("o_btbWrite", {1'b0, expected.btbWrite}, {1'b0, o_btbWrite});
            end
        end
    end

    // Run length guard
    initial begin
        cycleCount = 0;
        while (cycleCount <= timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run did not finish within %0d cycles", timeoutCycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        seed       = 93;
        checkEn    = 1'b0;
        errorCount = 0;
        vecCount   = 0;
        i_reset    = 1'b1;
        clearInputs();
        repeat (resetCycles) @(posedge clk);
        #1;
        i_reset = 1'b0;
        runTest(1, "forwarding priority");
        runTest(2, "load-use bubble");
        runTest(3, "condition codes");
        runTest(4, "prediction outcomes");
        runTest(5, "cache misses");
        runTest(6, "idle");
        $display("Totals: %0d vectors, %0d errors", vecCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/hazardPkg.sv
logic/forwardUnit.sv
logic/conditionCheck.sv
logic/branchResolver.sv
logic/stallUnit.sv
logic/hazardUnit.sv
verif/hazardUnitTb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module hazardUnitTb -Mdir obj_dir
	./obj_dir/VhazardUnitTb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
